/* src/csr_pkg.sv */
package csr_pkg;

    // User counter aliases, read only
    localparam logic [11:0] CYCLE     = 12'hC00;
    localparam logic [11:0] TIME      = 12'hC01;
    localparam logic [11:0] INSTRET   = 12'hC02;
    localparam logic [11:0] CYCLEH    = 12'hC80;
    localparam logic [11:0] TIMEH     = 12'hC81;
    localparam logic [11:0] INSTRETH  = 12'hC82;

    // Machine information
    localparam logic [11:0] MARCHID   = 12'hF12;
    localparam logic [11:0] MIMPID    = 12'hF13;

    // Machine trap setup
    localparam logic [11:0] MSTATUS   = 12'h300;
    localparam logic [11:0] MSTATUSH  = 12'h310;
    localparam logic [11:0] MISA      = 12'h301;
    localparam logic [11:0] MIE       = 12'h304;
    localparam logic [11:0] MTVEC     = 12'h305;

    // Machine trap handling
    localparam logic [11:0] MSCRATCH  = 12'h340;
    localparam logic [11:0] MEPC      = 12'h341;
    localparam logic [11:0] MCAUSE    = 12'h342;
    localparam logic [11:0] MTVAL     = 12'h343;
    localparam logic [11:0] MIP       = 12'h344;

    // Machine counters
    localparam logic [11:0] MCYCLE    = 12'hB00;
    localparam logic [11:0] MINSTRET  = 12'hB02;
    localparam logic [11:0] MCYCLEH   = 12'hB80;
    localparam logic [11:0] MINSTRETH = 12'hB82;

    // Writable time halves, not in the standard map
    localparam logic [11:0] MTIME     = 12'hB01;
    localparam logic [11:0] MTIMEH    = 12'hB81;

    // Constant information registers
    localparam logic [31:0] MARCHID_VALUE = 32'h0000_2EF8;
    localparam logic [31:0] MIMPID_VALUE  = 32'h0000_0001;
    localparam logic [31:0] MISA_VALUE    = 32'h4000_0100; // MXL 32, I extension

    // Number of 64-bit event counters
    localparam int NUM_COUNTERS = 3;

    // CSR operations as encoded in func3
    typedef enum logic [2:0] {
        CSR_RW  = 3'd1,
        CSR_RS  = 3'd2,
        CSR_RC  = 3'd3,
        CSR_RWI = 3'd5,
        CSR_RSI = 3'd6,
        CSR_RCI = 3'd7
    } csr_op_e;

    // Position of each counter in the counter array
    typedef enum logic [1:0] {
        CNT_CYCLE   = 2'd0,
        CNT_TIME    = 2'd1,
        CNT_INSTRET = 2'd2
    } counter_index_e;

endpackage

/* src/csr_op_decode.sv */
module csr_op_decode import csr_pkg::*; (
    input  logic                    csr_write_enable,
    input  logic [2:0]              func3,
    input  logic [4:0]              csr_immediate,
    input  logic [11:0]             csr_address,
    input  logic [31:0]             csr_data_in,
    input  logic [31:0]             old_value,
    output logic [31:0]             new_value,
    output logic [NUM_COUNTERS-1:0] counter_write_lo,
    output logic [NUM_COUNTERS-1:0] counter_write_hi,
    output logic                    trap_write_mepc,
    output logic                    trap_write_mscratch,
    output logic                    trap_write_mcause,
    output logic                    trap_write_mtval,
    output logic                    trap_write_mtvec
);

    csr_op_e     op;
    logic [31:0] operand;
    logic        op_valid;
    logic        read_only;
    logic        write_allowed;

    assign op = csr_op_e'(func3);

    // Bit 2 of func3 picks the immediate form
    assign operand = func3[2] ? {27'd0, csr_immediate} : csr_data_in;

    always_comb begin
        op_valid = 1'b1;
        case (op)
            CSR_RW, CSR_RWI: new_value = operand;
            CSR_RS, CSR_RSI: new_value = old_value | operand;
            CSR_RC, CSR_RCI: new_value = old_value & ~operand;
            default: begin
                new_value = old_value;
                op_valid  = 1'b0;         // Reserved encodings never write
            end
        endcase
    end

    // Top two address bits set means a read-only CSR
    assign read_only = (csr_address[11:10] == 2'b11) ||
                       (csr_address == MISA)    ||
                       (csr_address == MSTATUS) ||
                       (csr_address == MSTATUSH) ||
                       (csr_address == MIE)     ||
                       (csr_address == MIP);

    assign write_allowed = csr_write_enable && op_valid && !read_only;

    always_comb begin
        counter_write_lo    = '0;
        counter_write_hi    = '0;
        trap_write_mepc     = 1'b0;
        trap_write_mscratch = 1'b0;
        trap_write_mcause   = 1'b0;
        trap_write_mtval    = 1'b0;
        trap_write_mtvec    = 1'b0;
        if (write_allowed) begin
            case (csr_address)
                MCYCLE:    counter_write_lo[CNT_CYCLE]   = 1'b1;
                MCYCLEH:   counter_write_hi[CNT_CYCLE]   = 1'b1;
                MTIME:     counter_write_lo[CNT_TIME]    = 1'b1;
                MTIMEH:    counter_write_hi[CNT_TIME]    = 1'b1;
                MINSTRET:  counter_write_lo[CNT_INSTRET] = 1'b1;
                MINSTRETH: counter_write_hi[CNT_INSTRET] = 1'b1;
                MEPC:      trap_write_mepc     = 1'b1;
                MSCRATCH:  trap_write_mscratch = 1'b1;
                MCAUSE:    trap_write_mcause   = 1'b1;
                MTVAL:     trap_write_mtval    = 1'b1;
                MTVEC:     trap_write_mtvec    = 1'b1;
                default:   ;
            endcase
        end
    end

endmodule

/* src/csr_counter.sv */
module csr_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        count_enable,
    input  logic        write_lo,
    input  logic        write_hi,
    input  logic [31:0] write_data,
    output logic [63:0] count
);

    logic any_write;

    assign any_write = write_lo || write_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (any_write) begin
            // A half write wins over the increment on this edge
            if (write_lo) begin
                count[31:0] <= write_data;
            end
            if (write_hi) begin
                count[63:32] <= write_data;
            end
        end else if (count_enable) begin
            count <= count + 64'd1;
        end
    end

endmodule

/* src/csr_trap_regs.sv */
module csr_trap_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        trap_write_mepc,
    input  logic        trap_write_mscratch,
    input  logic        trap_write_mcause,
    input  logic        trap_write_mtval,
    input  logic        trap_write_mtvec,
    input  logic [31:0] new_value,
    input  logic        interruption_request_external,
    input  logic        interruption_request_timer,
    input  logic        interruption_request_software,
    input  logic [15:0] interruption_request_fast,
    output logic [31:0] mepc,
    output logic [31:0] mscratch,
    output logic [31:0] mcause,
    output logic [31:0] mtval,
    output logic [31:0] mtvec,
    output logic [31:0] mip
);

    logic [31:0] mip_next;

    // Standard pending bit positions, fast lines in the upper half
    assign mip_next = {
        interruption_request_fast,           // 31:16
        4'b0000,
        interruption_request_external,       // 11 MEIP
        3'b000,
        interruption_request_timer,          // 7 MTIP
        3'b000,
        interruption_request_software,       // 3 MSIP
        3'b000
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc     <= '0;
            mscratch <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mtvec    <= '0;
        end else begin
            if (trap_write_mepc) begin
                mepc <= {new_value[31:2], 2'b00};   // Word aligned
            end
            if (trap_write_mscratch) begin
                mscratch <= new_value;
            end
            if (trap_write_mcause) begin
                mcause <= new_value;
            end
            if (trap_write_mtval) begin
                mtval <= new_value;
            end
            if (trap_write_mtvec) begin
                mtvec <= new_value;
            end
        end
    end

    // Request lines sampled once per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mip <= '0;
        end else begin
            mip <= mip_next;
        end
    end

endmodule

/* src/csr_read_mux.sv */
module csr_read_mux import csr_pkg::*; (
    input  logic [11:0]                  csr_address,
    input  logic [NUM_COUNTERS-1:0][63:0] counter_values,
    input  logic [31:0]                  mepc,
    input  logic [31:0]                  mscratch,
    input  logic [31:0]                  mcause,
    input  logic [31:0]                  mtval,
    input  logic [31:0]                  mtvec,
    input  logic [31:0]                  mip,
    output logic [31:0]                  read_data
);

    counter_index_e counter_sel;
    logic           counter_hit;
    logic [63:0]    counter_full;
    logic [31:0]    counter_word;

    // User aliases and machine addresses share the same counters
    always_comb begin
        counter_sel = CNT_CYCLE;
        counter_hit = 1'b1;
        case (csr_address)
            CYCLE, CYCLEH, MCYCLE, MCYCLEH:             counter_sel = CNT_CYCLE;
            TIME, TIMEH, MTIME, MTIMEH:                 counter_sel = CNT_TIME;
            INSTRET, INSTRETH, MINSTRET, MINSTRETH:     counter_sel = CNT_INSTRET;
            default:                                    counter_hit = 1'b0;
        endcase
    end

    assign counter_full = counter_values[counter_sel];

    // Address bit 7 marks the high half in every counter address
    assign counter_word = csr_address[7] ? counter_full[63:32] : counter_full[31:0];

    always_comb begin
        if (counter_hit) begin
            read_data = counter_word;
        end else begin
            case (csr_address)
                MISA:     read_data = MISA_VALUE;
                MARCHID:  read_data = MARCHID_VALUE;
                MIMPID:   read_data = MIMPID_VALUE;
                MTVEC:    read_data = mtvec;
                MSCRATCH: read_data = mscratch;
                MEPC:     read_data = mepc;
                MCAUSE:   read_data = mcause;
                MTVAL:    read_data = mtval;
                MIP:      read_data = mip;
                default:  read_data = '0;       // Also mstatus, mstatush and mie
            endcase
        end
    end

endmodule

/* src/csr_unit.sv */
module csr_unit import csr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_write_enable,
    input  logic [2:0]  func3,
    input  logic [4:0]  csr_immediate,
    input  logic [11:0] csr_address,
    input  logic [31:0] csr_data_in,
    input  logic        interruption_request_external,
    input  logic        interruption_request_timer,
    input  logic        interruption_request_software,
    input  logic [15:0] interruption_request_fast,
    input  logic        time_tick,
    input  logic        instr_retired,
    output logic [31:0] csr_data_out
);

    logic [31:0]                   old_value;
    logic [31:0]                   new_value;
    logic [NUM_COUNTERS-1:0]       counter_write_lo;
    logic [NUM_COUNTERS-1:0]       counter_write_hi;
    logic [NUM_COUNTERS-1:0]       count_enable;
    logic [NUM_COUNTERS-1:0][63:0] counter_values;
    logic                          trap_write_mepc;
    logic                          trap_write_mscratch;
    logic                          trap_write_mcause;
    logic                          trap_write_mtval;
    logic                          trap_write_mtvec;
    logic [31:0]                   mepc;
    logic [31:0]                   mscratch;
    logic [31:0]                   mcause;
    logic [31:0]                   mtval;
    logic [31:0]                   mtvec;
    logic [31:0]                   mip;

    assign count_enable[CNT_CYCLE]   = 1'b1;          // Counts every cycle
    assign count_enable[CNT_TIME]    = time_tick;
    assign count_enable[CNT_INSTRET] = instr_retired;

    assign csr_data_out = old_value;

    csr_op_decode i_csr_op_decode (
        .csr_write_enable    (csr_write_enable),
        .func3               (func3),
        .csr_immediate       (csr_immediate),
        .csr_address         (csr_address),
        .csr_data_in         (csr_data_in),
        .old_value           (old_value),
        .new_value           (new_value),
        .counter_write_lo    (counter_write_lo),
        .counter_write_hi    (counter_write_hi),
        .trap_write_mepc     (trap_write_mepc),
        .trap_write_mscratch (trap_write_mscratch),
        .trap_write_mcause   (trap_write_mcause),
        .trap_write_mtval    (trap_write_mtval),
        .trap_write_mtvec    (trap_write_mtvec)
    );

    for (genvar i = 0; i < NUM_COUNTERS; i++) begin : g_counter
        localparam counter_index_e IDX = counter_index_e'(i);

        csr_counter i_csr_counter (
            .clk          (clk),
            .reset        (reset),
            .count_enable (count_enable[IDX]),
            .write_lo     (counter_write_lo[IDX]),
            .write_hi     (counter_write_hi[IDX]),
            .write_data   (new_value),
            .count        (counter_values[IDX])
        );
    end

    csr_trap_regs i_csr_trap_regs (
        .clk                           (clk),
        .reset                         (reset),
        .trap_write_mepc               (trap_write_mepc),
        .trap_write_mscratch           (trap_write_mscratch),
        .trap_write_mcause             (trap_write_mcause),
        .trap_write_mtval              (trap_write_mtval),
        .trap_write_mtvec              (trap_write_mtvec),
        .new_value                     (new_value),
        .interruption_request_external (interruption_request_external),
        .interruption_request_timer    (interruption_request_timer),
        .interruption_request_software (interruption_request_software),
        .interruption_request_fast     (interruption_request_fast),
        .mepc                          (mepc),
        .mscratch                      (mscratch),
        .mcause                        (mcause),
        .mtval                         (mtval),
        .mtvec                         (mtvec),
        .mip                           (mip)
    );

    csr_read_mux i_csr_read_mux (
        .csr_address    (csr_address),
        .counter_values (counter_values),
        .mepc           (mepc),
        .mscratch       (mscratch),
        .mcause         (mcause),
        .mtval          (mtval),
        .mtvec          (mtvec),
        .mip            (mip),
        .read_data      (old_value)
    );

endmodule

/* testbench/csr_unit_sva.sv */
module csr_unit_sva import csr_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic [11:0] csr_address,
    input logic [31:0] csr_data_out,
    input logic        interruption_request_external,
    input logic        interruption_request_timer,
    input logic        interruption_request_software,
    input logic [15:0] interruption_request_fast
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [31:0] request_vector;

    // Pending bits at their mip positions
    assign request_vector = {interruption_request_fast, 4'b0000, interruption_request_external,
                             3'b000, interruption_request_timer, 3'b000,
                             interruption_request_software, 3'b000};

    misa_constant: assert property (@(posedge clk) disable iff (reset)
        (csr_address == MISA) |-> (csr_data_out == MISA_VALUE))
        else $error("MISA read differs from its constant value");

    mepc_aligned: assert property (@(posedge clk) disable iff (reset)
        (csr_address == MEPC) |-> (csr_data_out[1:0] == 2'b00))
        else $error("MEPC read has low bits set");

    mip_one_cycle_late: assert property (@(posedge clk) disable iff (reset)
        (csr_address == MIP && !$past(reset)) |-> (csr_data_out == $past(request_vector)))
        else $error("MIP read does not match the previous request lines");

endmodule

/* testbench/csr_unit_tb.sv */
module csr_unit_tb import csr_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk;
    logic        reset;
    logic        csr_write_enable;
    logic [2:0]  func3;
    logic [4:0]  csr_immediate;
    logic [11:0] csr_address;
    logic [31:0] csr_data_in;
    logic        interruption_request_external;
    logic        interruption_request_timer;
    logic        interruption_request_software;
    logic [15:0] interruption_request_fast;
    logic        time_tick;
    logic        instr_retired;
    logic [31:0] csr_data_out;

    integer      seed = 68;
    int          cycle_count = 0;
    logic [11:0] addr_list [0:31];
    logic [11:0] trap_addrs [0:4];
    logic [11:0] ro_addrs [0:8];
    logic [2:0]  op_codes [0:5];
    logic [4:0]  addr_index;
    logic [31:0] expected;

    // Shadow model state
    logic [63:0] m_cycle, m_time, m_instret;
    logic [31:0] m_mepc, m_mscratch, m_mcause, m_mtval, m_mtvec, m_mip;
    logic [31:0] m_operand, m_old, m_result;
    logic        m_write;

    csr_unit i_csr_unit (.*);

    bind csr_unit csr_unit_sva i_csr_unit_sva (
        .clk                           (clk),
        .reset                         (reset),
        .csr_address                   (csr_address),
        .csr_data_out                  (csr_data_out),
        .interruption_request_external (interruption_request_external),
        .interruption_request_timer    (interruption_request_timer),
        .interruption_request_software (interruption_request_software),
        .interruption_request_fast     (interruption_request_fast)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        case (addr)
            CYCLE, MCYCLE:       return m_cycle[31:0];
            CYCLEH, MCYCLEH:     return m_cycle[63:32];
            TIME, MTIME:         return m_time[31:0];
            TIMEH, MTIMEH:       return m_time[63:32];
            INSTRET, MINSTRET:   return m_instret[31:0];
            INSTRETH, MINSTRETH: return m_instret[63:32];
            MISA:                return MISA_VALUE;
            MARCHID:             return MARCHID_VALUE;
            MIMPID:              return MIMPID_VALUE;
            MTVEC:               return m_mtvec;
            MSCRATCH:            return m_mscratch;
            MEPC:                return m_mepc;
            MCAUSE:              return m_mcause;
            MTVAL:               return m_mtval;
            MIP:                 return m_mip;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic is_writable(input logic [11:0] addr);
        return (addr[11:10] != 2'b11) && (addr != MISA) && (addr != MSTATUS) &&
               (addr != MSTATUSH) && (addr != MIE) && (addr != MIP);
    endfunction

    function automatic logic [63:0] next_count(input logic [63:0] cur, input logic enable,
            input logic write_lo, input logic write_hi, input logic [31:0] data);
        logic [63:0] result;
        result = cur;
        if (write_lo || write_hi) begin
            if (write_lo) begin
                result[31:0] = data;
            end
            if (write_hi) begin
                result[63:32] = data;
            end
        end else if (enable) begin
            result = cur + 64'd1;
        end
        return result;
    endfunction

    // Model steps on the same edge as the DUT, from the inputs alone
    always @(posedge clk) begin
        if (reset) begin
            m_cycle = '0;
            m_time = '0;
            m_instret = '0;
            {m_mepc, m_mscratch, m_mcause, m_mtval, m_mtvec, m_mip} = '0;
        end else begin
            m_operand = func3[2] ? {27'd0, csr_immediate} : csr_data_in;
            m_old = expected_read(csr_address);
            case (func3[1:0])
                2'b01:   m_result = m_operand;
                2'b10:   m_result = m_old | m_operand;
                2'b11:   m_result = m_old & ~m_operand;
                default: m_result = m_old;
            endcase
            m_write = csr_write_enable && (func3[1:0] != 2'b00) && is_writable(csr_address);
            m_cycle = next_count(m_cycle, 1'b1, m_write && (csr_address == MCYCLE),
                                 m_write && (csr_address == MCYCLEH), m_result);
            m_time = next_count(m_time, time_tick, m_write && (csr_address == MTIME),
                                m_write && (csr_address == MTIMEH), m_result);
            m_instret = next_count(m_instret, instr_retired, m_write && (csr_address == MINSTRET),
                                   m_write && (csr_address == MINSTRETH), m_result);
            if (m_write && csr_address == MEPC) begin
                m_mepc = {m_result[31:2], 2'b00};
            end
            if (m_write && csr_address == MSCRATCH) begin
                m_mscratch = m_result;
            end
            if (m_write && csr_address == MCAUSE) begin
                m_mcause = m_result;
            end
            if (m_write && csr_address == MTVAL) begin
                m_mtval = m_result;
            end
            if (m_write && csr_address == MTVEC) begin
                m_mtvec = m_result;
            end
            m_mip = {interruption_request_fast, 4'b0000, interruption_request_external, 3'b000,
                     interruption_request_timer, 3'b000, interruption_request_software, 3'b000};
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Read port checked halfway through the low phase
    initial begin
        forever begin
            @(negedge clk);
            #25;
            if (!reset) begin
                expected = expected_read(csr_address);
                assert (csr_data_out === expected) else begin
                    fail_run($sformatf("MISMATCH csr_data_out at address %h: expected %h, got %h",
                                       csr_address, expected, csr_data_out));
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= 2000) begin    // Tests need about 700 cycles
                fail_run("Timeout: the test sequence did not finish within 2000 cycles");
            end
        end
    end

    task automatic set_idle();
        csr_write_enable = 1'b0;
        func3 = 3'd0;
        csr_immediate = 5'd0;
        csr_data_in = 32'd0;
        time_tick = 1'b0;
        instr_retired = 1'b0;
        interruption_request_external = 1'b0;
        interruption_request_timer = 1'b0;
        interruption_request_software = 1'b0;
        interruption_request_fast = 16'd0;
    endtask

    task automatic read_csr(input logic [11:0] addr);
        @(negedge clk);
        set_idle();
        csr_address = addr;
    endtask

    task automatic write_csr(input logic [2:0] op, input logic [11:0] addr,
            input logic [31:0] data, input logic [4:0] imm);
        @(negedge clk);
        set_idle();
        csr_write_enable = 1'b1;
        func3 = op;
        csr_address = addr;
        csr_data_in = data;
        csr_immediate = imm;
    endtask

    initial begin
        addr_list = '{CYCLE, TIME, INSTRET, CYCLEH, TIMEH, INSTRETH, MARCHID, MIMPID,
                      MSTATUS, MSTATUSH, MISA, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE,
                      MTVAL, MIP, MCYCLE, MINSTRET, MCYCLEH, MINSTRETH, MTIME, MTIMEH,
                      12'h000, 12'h345, 12'h302, 12'hB03, 12'hC03, 12'hF14, 12'h7C0, 12'hB83};
        trap_addrs = '{MSCRATCH, MTVEC, MCAUSE, MTVAL, MEPC};
        ro_addrs = '{CYCLE, TIMEH, INSTRET, MISA, MARCHID, MIMPID, MSTATUS, MIE, MIP};
        op_codes = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
        reset = 1'b1;
        csr_address = 12'd0;
        set_idle();
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Every address after reset, then the cycle counter running
        for (int i = 0; i < 32; i++) begin
            read_csr(addr_list[i]);
        end
        repeat (10) read_csr(CYCLE);

        // All operations on the trap registers
        for (int r = 0; r < 5; r++) begin
            for (int k = 0; k < 6; k++) begin
                write_csr(op_codes[k], trap_addrs[r], $random(seed), 5'($random(seed)));
                read_csr(trap_addrs[r]);
            end
        end

        // Random tick and retire pulses
        for (int i = 0; i < 60; i++) begin
            read_csr((i % 2 == 1) ? TIME : INSTRET);
            time_tick = 1'($random(seed));
            instr_retired = 1'($random(seed));
        end
        for (int i = 0; i < 6; i++) begin
            write_csr(CSR_RW, addr_list[18 + i], $random(seed), 5'd0);
            time_tick = 1'b1;                 // Write must win over the increment
            instr_retired = 1'b1;
            read_csr(addr_list[18 + i]);
        end

        // Writes to read-only addresses
        for (int i = 0; i < 9; i++) begin
            write_csr(op_codes[i % 6], ro_addrs[i], $random(seed), 5'($random(seed)));
            read_csr(ro_addrs[i]);
        end
        for (int i = 0; i < 32; i++) begin
            read_csr(addr_list[i]);           // No other register changed either
        end

        // Interrupt request patterns
        for (int i = 0; i < 40; i++) begin
            read_csr(MIP);
            interruption_request_external = 1'($random(seed));
            interruption_request_timer = 1'($random(seed));
            interruption_request_software = 1'($random(seed));
            interruption_request_fast = 16'($random(seed));
        end

        // Random mix
        for (int i = 0; i < 400; i++) begin
            @(negedge clk);
            addr_index = 5'($random(seed));
            csr_address = addr_list[addr_index];
            csr_write_enable = 1'($random(seed));
            func3 = 3'($random(seed));
            csr_data_in = $random(seed);
            csr_immediate = 5'($random(seed));
            time_tick = 1'($random(seed));
            instr_retired = 1'($random(seed));
            interruption_request_external = 1'($random(seed));
            interruption_request_timer = 1'($random(seed));
            interruption_request_software = 1'($random(seed));
            interruption_request_fast = 16'($random(seed));
        end

        read_csr(MCYCLE);
        @(negedge clk);
        #40;
        $display("** PASS **");
        $finish;
    end

endmodule

/* build.f */
src/csr_pkg.sv
src/csr_op_decode.sv
src/csr_counter.sv
src/csr_trap_regs.sv
src/csr_read_mux.sv
src/csr_unit.sv
testbench/csr_unit_sva.sv
testbench/csr_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module csr_unit_tb \
    -f build.f \
    --Mdir obj_dir \
    -o csr_unit_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/csr_unit_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
fi
exit $sim_status
